// ==== rtl/bridge_cfg_pkg.sv ====
`default_nettype none

package bridge_cfg_pkg;

	// Unit counts on the core side
	localparam int HDD_UNITS    = 2;
	localparam int FLOPPY_UNITS = 2;

	// Host block slots, hard disks first, then floppies
	localparam int SD_SLOTS         = 4;
	localparam int SLOT_FLOPPY_BASE = 2;

	// Menu status word bit positions
	localparam int STATUS_WARM_BIT     = 0;
	localparam int STATUS_COLD_BIT     = 1;
	localparam int STATUS_AR_LSB       = 8;
	localparam int STATUS_SELFTEST_BIT = 10;

	// Aspect ratio when the menu field is zero (4:3 display)
	localparam int ASPECT_DEFAULT_X = 4;
	localparam int ASPECT_DEFAULT_Y = 3;

	// Field widths
	localparam int STATUS_W = 32;
	localparam int SECTOR_W = 16;
	localparam int LBA_W    = 32;
	localparam int IMG_W    = 64;
	localparam int ASPECT_W = 13;
	localparam int AR_SEL_W = 2;

	typedef logic [STATUS_W-1:0] status_word_t;
	typedef logic [SECTOR_W-1:0] sector_t;
	typedef logic [LBA_W-1:0]    lba_t;
	typedef logic [IMG_W-1:0]    img_size_t;
	typedef logic [SD_SLOTS-1:0] slot_mask_t;
	typedef logic                hdd_unit_t;
	// Bit 12 set would mean scaled size rather than a ratio
	typedef logic [ASPECT_W-1:0] aspect_t;
	typedef logic [AR_SEL_W-1:0] ar_sel_t;

endpackage

`default_nettype wire

// ==== rtl/blockdev_types_pkg.sv ====
`default_nettype none

package blockdev_types_pkg;

	// One sector transfer asked for by the core
	typedef struct packed {
		bridge_cfg_pkg::sector_t   sector;
		bridge_cfg_pkg::hdd_unit_t unit;
		// High for a write to the image, low for a read
		logic                      write;
	} hdd_req_t;

	// Mount report from the host
	typedef struct packed {
		// One-cycle pulse per slot
		bridge_cfg_pkg::slot_mask_t mounted;
		// Zero size means the image was removed
		bridge_cfg_pkg::img_size_t  size;
		logic                       readonly;
	} image_event_t;

	// Hard-disk unit state seen by the core
	typedef struct packed {
		logic [bridge_cfg_pkg::HDD_UNITS-1:0] mounted;
		logic [bridge_cfg_pkg::HDD_UNITS-1:0] protect;
	} hdd_status_t;

	// Floppy drive state seen by the track loaders
	typedef struct packed {
		logic [bridge_cfg_pkg::FLOPPY_UNITS-1:0] ready;
		// Toggles on every mount report for the drive
		logic [bridge_cfg_pkg::FLOPPY_UNITS-1:0] change;
	} floppy_status_t;

	// Request controller states
	typedef enum logic [1:0] {
		// Waiting for a core request, ready high
		HDD_IDLE,
		// Host read or write line raised, waiting for ack
		HDD_REQUEST,
		// Ack high, sector data moving
		HDD_TRANSFER
	} hdd_state_e;

endpackage

`default_nettype wire

// ==== rtl/core_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_control (
	input  logic                         reset,
	input  logic                         pll_locked,
	input  bridge_cfg_pkg::status_word_t status,
	input  logic                         user_button,
	input  logic                         kbd_warm_reset,
	input  logic                         kbd_cold_reset,
	output logic                         core_reset,
	output logic                         cold_reset,
	output logic                         selftest_override,
	output bridge_cfg_pkg::aspect_t      video_arx,
	output bridge_cfg_pkg::aspect_t      video_ary
);
	import bridge_cfg_pkg::*;

	logic    warm_trigger;
	logic    cold_trigger;
	logic    power_reset;
	ar_sel_t ar;
	ar_sel_t ar_minus_one;

	// Menu entries and keyboard combos both request a reset
	assign warm_trigger = status[STATUS_WARM_BIT] | kbd_warm_reset;
	assign cold_trigger = status[STATUS_COLD_BIT] | kbd_cold_reset;

	// Board reset or PLL still settling
	assign power_reset = reset | ~pll_locked;

	// Any source resets the core
	assign core_reset = power_reset | warm_trigger | cold_trigger | user_button;

	// Cold only for power-up or an explicit cold request
	assign cold_reset = power_reset | cold_trigger;

	assign selftest_override = status[STATUS_SELFTEST_BIT];

	// Aspect ratio menu field
	assign ar           = status[STATUS_AR_LSB +: $bits(ar_sel_t)];
	assign ar_minus_one = ar - ar_sel_t'(1);

	// Zero selects the 4:3 default
	// Other values pass field minus one with a zero height
	always_comb begin
		if (ar == '0) begin
			video_arx = aspect_t'(ASPECT_DEFAULT_X);
			video_ary = aspect_t'(ASPECT_DEFAULT_Y);
		end else begin
			video_arx = aspect_t'(ar_minus_one);
			video_ary = '0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/image_mount_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module image_mount_tracker (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  blockdev_types_pkg::image_event_t   image_event,
	output blockdev_types_pkg::hdd_status_t    hdd_status,
	output blockdev_types_pkg::floppy_status_t floppy_status
);
	import bridge_cfg_pkg::*;
	import blockdev_types_pkg::*;

	logic image_present;

	// Empty size on a report means eject
	assign image_present = (image_event.size != '0);

	// Hard-disk units sit on slots 0 and 1
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdd_status <= '0;
		end else begin
			for (int unit = 0; unit < HDD_UNITS; unit++) begin
				if (image_event.mounted[unit]) begin
					hdd_status.mounted[unit] <= image_present;
					// Protect follows the host read-only flag
					hdd_status.protect[unit] <= image_event.readonly;
				end
			end
		end
	end

	// Floppy drives sit above the hard-disk slots
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			floppy_status <= '0;
		end else begin
			for (int drive = 0; drive < FLOPPY_UNITS; drive++) begin
				if (image_event.mounted[SLOT_FLOPPY_BASE + drive]) begin
					floppy_status.ready[drive] <= image_present;
					// Track loader watches for a flip, insert and eject alike
					floppy_status.change[drive] <= ~floppy_status.change[drive];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/hdd_request_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdd_request_ctrl (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  blockdev_types_pkg::hdd_req_t hdd_req,
	input  logic                         hdd_req_valid,
	output logic                         hdd_req_ready,
	input  bridge_cfg_pkg::slot_mask_t   sd_ack,
	input  logic                         sd_buff_wr,
	output bridge_cfg_pkg::slot_mask_t   sd_rd,
	output bridge_cfg_pkg::slot_mask_t   sd_wr,
	output bridge_cfg_pkg::lba_t         sd_lba,
	output logic                         cpu_wait,
	output logic                         hdd_buff_we
);
	import bridge_cfg_pkg::*;
	import blockdev_types_pkg::*;

	hdd_state_e           state;
	hdd_unit_t            active_unit;
	sector_t              active_sector;
	logic [HDD_UNITS-1:0] req_onehot;
	logic [HDD_UNITS-1:0] rd_hd;
	logic [HDD_UNITS-1:0] wr_hd;
	logic                 accept;
	logic                 ack_active;
	logic                 ack_prev;
	logic                 ack_rise;
	logic                 ack_fall;

	// One request in flight, ready only while idle
	assign hdd_req_ready = (state == HDD_IDLE);
	assign accept        = hdd_req_valid & hdd_req_ready;

	// Slot bit of the requested unit
	always_comb begin
		req_onehot                 = '0;
		req_onehot[hdd_req.unit]   = 1'b1;
	end

	// Ack of the unit being served, other slot ignored
	assign ack_active = sd_ack[active_unit];
	assign ack_rise   = ack_active & ~ack_prev;
	assign ack_fall   = ~ack_active & ack_prev;

	// Sector buffer writes only during our own transfer
	assign hdd_buff_we = sd_buff_wr & ack_active;

	// Zero-extension keeps the floppy slot bits low
	assign sd_rd = slot_mask_t'(rd_hd);
	assign sd_wr = slot_mask_t'(wr_hd);

	// Both hard-disk slots see the same address
	assign sd_lba = lba_t'(active_sector);

	// Sector held for the whole transfer
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			active_sector <= hdd_req.sector;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= HDD_IDLE;
			active_unit <= '0;
			rd_hd       <= '0;
			wr_hd       <= '0;
			cpu_wait    <= 1'b0;
			ack_prev    <= 1'b0;
		end else begin
			ack_prev <= ack_active;
			unique case (state)
				HDD_IDLE: begin
					if (accept) begin
						active_unit <= hdd_req.unit;
						// Read or write line on that unit's slot
						rd_hd       <= hdd_req.write ? '0 : req_onehot;
						wr_hd       <= hdd_req.write ? req_onehot : '0;
						// Stall the CPU until the host is done
						cpu_wait    <= 1'b1;
						// Previous sample belongs to the old unit
						ack_prev    <= 1'b0;
						state       <= HDD_REQUEST;
					end
				end
				HDD_REQUEST: begin
					// Host took the request
					if (ack_rise) begin
						rd_hd <= '0;
						wr_hd <= '0;
						state <= HDD_TRANSFER;
					end
				end
				HDD_TRANSFER: begin
					// Ack dropped, sector complete
					if (ack_fall) begin
						cpu_wait <= 1'b0;
						state    <= HDD_IDLE;
					end
				end
				default: begin
					state <= HDD_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/blockdev_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module blockdev_bridge (
	input  logic                               clk_sys,
	input  logic                               reset,
	// Reset sources and menu
	input  logic                               pll_locked,
	input  bridge_cfg_pkg::status_word_t       status,
	input  logic                               user_button,
	input  logic                               kbd_warm_reset,
	input  logic                               kbd_cold_reset,
	// Host mount reports
	input  blockdev_types_pkg::image_event_t   image_event,
	// Core sector requests
	input  blockdev_types_pkg::hdd_req_t       hdd_req,
	input  logic                               hdd_req_valid,
	output logic                               hdd_req_ready,
	// Host block side
	input  bridge_cfg_pkg::slot_mask_t         sd_ack,
	input  logic                               sd_buff_wr,
	output bridge_cfg_pkg::slot_mask_t         sd_rd,
	output bridge_cfg_pkg::slot_mask_t         sd_wr,
	output bridge_cfg_pkg::lba_t               sd_lba,
	// Back to the core
	output logic                               cpu_wait,
	output logic                               hdd_buff_we,
	output blockdev_types_pkg::hdd_status_t    hdd_status,
	output blockdev_types_pkg::floppy_status_t floppy_status,
	output logic                               core_reset,
	output logic                               cold_reset,
	output logic                               selftest_override,
	output bridge_cfg_pkg::aspect_t            video_arx,
	output bridge_cfg_pkg::aspect_t            video_ary
);

	// Reset combine and menu decode
	core_control core_control_inst (
		.reset             (reset),
		.pll_locked        (pll_locked),
		.status            (status),
		.user_button       (user_button),
		.kbd_warm_reset    (kbd_warm_reset),
		.kbd_cold_reset    (kbd_cold_reset),
		.core_reset        (core_reset),
		.cold_reset        (cold_reset),
		.selftest_override (selftest_override),
		.video_arx         (video_arx),
		.video_ary         (video_ary)
	);

	// Mount state for all four slots
	image_mount_tracker image_mount_tracker_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.image_event   (image_event),
		.hdd_status    (hdd_status),
		.floppy_status (floppy_status)
	);

	// Hard-disk slots 0 and 1
	hdd_request_ctrl hdd_request_ctrl_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.hdd_req       (hdd_req),
		.hdd_req_valid (hdd_req_valid),
		.hdd_req_ready (hdd_req_ready),
		.sd_ack        (sd_ack),
		.sd_buff_wr    (sd_buff_wr),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.sd_lba        (sd_lba),
		.cpu_wait      (cpu_wait),
		.hdd_buff_we   (hdd_buff_we)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_bridge_model.svh ====
`ifndef TB_BRIDGE_MODEL_SVH
`define TB_BRIDGE_MODEL_SVH

	// Reset decode outputs checked together
	typedef struct packed {
		logic core_reset;
		logic cold_reset;
		logic selftest;
	} reset_outputs_t;

	// Shared random stream
	logic [31:0] lfsr_state = 32'd89012;

	// Right-shift Galois step
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken with the low bit first
	function automatic logic [63:0] rand_bits(input int count);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < count; i++) begin
			v[i]       = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic rand_bit();
		logic [63:0] v;
		v = rand_bits(1);
		return v[0];
	endfunction

	// Cold sources are a subset of the core reset sources
	function automatic reset_outputs_t ref_reset_outputs(input logic rst, input logic locked,
			input status_word_t st, input logic button, input logic warm_key,
			input logic cold_key);
		reset_outputs_t r;
		r.cold_reset = rst | ~locked | st[STATUS_COLD_BIT] | cold_key;
		r.core_reset = r.cold_reset | st[STATUS_WARM_BIT] | warm_key | button;
		r.selftest   = st[STATUS_SELFTEST_BIT];
		return r;
	endfunction

	// Zero field gives 4:3 and any other the field minus one
	function automatic aspect_t ref_arx(input ar_sel_t ar);
		return (ar == 0) ? aspect_t'(ASPECT_DEFAULT_X) : aspect_t'(ar - 1);
	endfunction

	function automatic aspect_t ref_ary(input ar_sel_t ar);
		return (ar == 0) ? aspect_t'(ASPECT_DEFAULT_Y) : aspect_t'(0);
	endfunction

	// Hard-disk state after one mount report
	function automatic hdd_status_t ref_hdd_after(input hdd_status_t prev,
			input image_event_t ev);
		hdd_status_t next;
		next = prev;
		for (int u = 0; u < HDD_UNITS; u++) begin
			if (ev.mounted[u]) begin
				next.mounted[u] = (ev.size != 0);
				next.protect[u] = ev.readonly;
			end
		end
		return next;
	endfunction

	// Floppy state after one mount report with the change bit flipped
	function automatic floppy_status_t ref_floppy_after(input floppy_status_t prev,
			input image_event_t ev);
		floppy_status_t next;
		next = prev;
		for (int d = 0; d < FLOPPY_UNITS; d++) begin
			if (ev.mounted[SLOT_FLOPPY_BASE + d]) begin
				next.ready[d]  = (ev.size != 0);
				next.change[d] = ~prev.change[d];
			end
		end
		return next;
	endfunction

	// Only the requested unit's slot bit
	function automatic slot_mask_t ref_slot_mask(input hdd_unit_t unit, input logic active);
		slot_mask_t m;
		m = '0;
		if (active) begin
			m[unit] = 1'b1;
		end
		return m;
	endfunction

	function automatic lba_t ref_lba(input sector_t sector);
		return {{(LBA_W - SECTOR_W){1'b0}}, sector};
	endfunction

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("FAILED at %0d ns: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_reset_outputs(input reset_outputs_t got, input reset_outputs_t exp);
		if (got !== exp) begin
			stop_run($sformatf("FAILED at %0d ns: core/cold/selftest is %b, expected %b",
				$time, got, exp));
		end
	endtask

	task automatic check_aspect(input string what, input aspect_t got, input aspect_t exp);
		if (got !== exp) begin
			stop_run($sformatf("FAILED at %0d ns: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_hdd_status(input hdd_status_t got, input hdd_status_t exp);
		if (got !== exp) begin
			stop_run($sformatf("FAILED at %0d ns: hdd_status is %b, expected %b",
				$time, got, exp));
		end
	endtask

	task automatic check_floppy_status(input floppy_status_t got, input floppy_status_t exp);
		if (got !== exp) begin
			stop_run($sformatf("FAILED at %0d ns: floppy_status is %b, expected %b",
				$time, got, exp));
		end
	endtask

	task automatic check_slot_mask(input string what, input slot_mask_t got,
			input slot_mask_t exp);
		if (got !== exp) begin
			stop_run($sformatf("FAILED at %0d ns: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_lba(input lba_t got, input lba_t exp);
		if (got !== exp) begin
			stop_run($sformatf("FAILED at %0d ns: sd_lba is %h, expected %h",
				$time, got, exp));
		end
	endtask

`endif

// ==== testbench/tb_blockdev_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_blockdev_bridge;
	import bridge_cfg_pkg::*;
	import blockdev_types_pkg::*;

	// Longest any single wait may last in cycles
	localparam int WAIT_LIMIT = 100;

	logic           clk_sys;
	logic           reset;
	logic           pll_locked;
	status_word_t   status;
	logic           user_button;
	logic           kbd_warm_reset;
	logic           kbd_cold_reset;
	image_event_t   image_event;
	hdd_req_t       hdd_req;
	logic           hdd_req_valid;
	logic           hdd_req_ready;
	slot_mask_t     sd_ack;
	logic           sd_buff_wr;
	slot_mask_t     sd_rd;
	slot_mask_t     sd_wr;
	lba_t           sd_lba;
	logic           cpu_wait;
	logic           hdd_buff_we;
	hdd_status_t    hdd_status;
	floppy_status_t floppy_status;
	logic           core_reset;
	logic           cold_reset;
	logic           selftest_override;
	aspect_t        video_arx;
	aspect_t        video_ary;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	`include "tb_bridge_model.svh"

	blockdev_bridge blockdev_bridge_inst (.*);

	// 50 MHz system clock
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Inputs change 2 ns after the rising edge
	task automatic drive_point();
		@(posedge clk_sys);
		#2;
	endtask

	// Outputs read mid-cycle
	task automatic sample_point();
		@(negedge clk_sys);
	endtask

	function automatic hdd_req_t random_request();
		hdd_req_t r;
		r.sector = sector_t'(rand_bits(SECTOR_W));
		r.unit   = rand_bit();
		r.write  = rand_bit();
		return r;
	endfunction

	// Raise valid and wait until the bridge will take it at the next edge
	task automatic issue_request(input hdd_req_t req);
		int waited;
		drive_point();
		hdd_req       = req;
		hdd_req_valid = 1'b1;
		waited        = 0;
		sample_point();
		while (!hdd_req_ready) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_run("Timeout: hdd_req_ready never rose for a new request");
			end
			sample_point();
		end
	endtask

	// Follows one accepted request until cpu_wait drops
	task automatic track_request(input hdd_req_t req);
		logic acked;
		logic done;
		logic ack_seen;
		int   cycles;
		acked    = 1'b0;
		done     = 1'b0;
		ack_seen = 1'b0;
		cycles   = 0;
		while (!done) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_run("Timeout: request never completed, host ack did not fall");
			end
			sample_point();
			// Ack level the DUT saw at the edge just passed
			if (!acked && ack_seen) begin
				acked = 1'b1;
			end else if (acked && !ack_seen) begin
				done = 1'b1;
			end
			check_slot_mask("sd_rd", sd_rd, ref_slot_mask(req.unit, !req.write && !acked));
			check_slot_mask("sd_wr", sd_wr, ref_slot_mask(req.unit, req.write && !acked));
			check_lba(sd_lba, ref_lba(req.sector));
			check_bit("cpu_wait", cpu_wait, !done);
			check_bit("hdd_req_ready", hdd_req_ready, done);
			// Buffer strobe only through the served unit's ack
			check_bit("hdd_buff_we", hdd_buff_we, sd_buff_wr & sd_ack[req.unit]);
			ack_seen = sd_ack[req.unit];
		end
	endtask

	// Host answers with a random delay and a random transfer length
	initial begin : host_model
		slot_mask_t pending;
		hdd_unit_t  slot;
		int         delay;
		int         hold;
		sd_ack     = '0;
		sd_buff_wr = 1'b0;
		forever begin
			sample_point();
			pending = (sd_rd | sd_wr) & slot_mask_t'(2'b11);
			if (pending != '0) begin
				slot  = pending[1];
				delay = int'(rand_bits(3));
				hold  = 1 + int'(rand_bits(3));
				// Stray ack on the other disk slot with a buffer write
				drive_point();
				sd_ack[!slot] = rand_bit();
				sd_buff_wr    = sd_ack[!slot];
				drive_point();
				sd_ack     = '0;
				sd_buff_wr = 1'b0;
				repeat (delay) drive_point();
				sd_ack[slot] = 1'b1;
				// Sector data moves while ack is high
				repeat (hold) begin
					drive_point();
					sd_buff_wr = rand_bit();
				end
				drive_point();
				sd_ack     = '0;
				sd_buff_wr = 1'b0;
			end
		end
	end

	initial begin : stimulus
		reset_outputs_t got_reset;
		image_event_t   ev;
		hdd_status_t    exp_hdd;
		floppy_status_t exp_floppy;
		hdd_req_t       req_a;
		hdd_req_t       req_b;
		reset          = 1'b1;
		pll_locked     = 1'b1;
		status         = '0;
		user_button    = 1'b0;
		kbd_warm_reset = 1'b0;
		kbd_cold_reset = 1'b0;
		image_event    = '0;
		hdd_req        = '0;
		hdd_req_valid  = 1'b0;
		repeat (3) @(posedge clk_sys);
		#2;
		reset = 1'b0;

		// Idle state straight after reset
		sample_point();
		check_slot_mask("sd_rd", sd_rd, '0);
		check_slot_mask("sd_wr", sd_wr, '0);
		check_bit("cpu_wait", cpu_wait, 1'b0);
		check_bit("hdd_req_ready", hdd_req_ready, 1'b1);
		check_hdd_status(hdd_status, '0);
		check_floppy_status(floppy_status, '0);

		// Each reset source on its own, last step with only the self-test bit
		for (int src = 0; src < 8; src++) begin
			drive_point();
			reset                       = (src == 0);
			pll_locked                  = (src != 1);
			user_button                 = (src == 2);
			kbd_warm_reset              = (src == 3);
			kbd_cold_reset              = (src == 4);
			status                      = '0;
			status[STATUS_WARM_BIT]     = (src == 5);
			status[STATUS_COLD_BIT]     = (src == 6);
			status[STATUS_SELFTEST_BIT] = (src == 7);
			sample_point();
			got_reset = {core_reset, cold_reset, selftest_override};
			check_reset_outputs(got_reset, ref_reset_outputs(reset, pll_locked, status,
				user_button, kbd_warm_reset, kbd_cold_reset));
		end

		// Random reset sources and menu words
		repeat (40) begin
			drive_point();
			reset          = rand_bit();
			pll_locked     = rand_bit();
			user_button    = rand_bit();
			kbd_warm_reset = rand_bit();
			kbd_cold_reset = rand_bit();
			status         = status_word_t'(rand_bits(STATUS_W));
			sample_point();
			got_reset = {core_reset, cold_reset, selftest_override};
			check_reset_outputs(got_reset, ref_reset_outputs(reset, pll_locked, status,
				user_button, kbd_warm_reset, kbd_cold_reset));
		end
		drive_point();
		reset          = 1'b0;
		pll_locked     = 1'b1;
		user_button    = 1'b0;
		kbd_warm_reset = 1'b0;
		kbd_cold_reset = 1'b0;

		// Every aspect menu value
		for (int ar = 0; ar < 4; ar++) begin
			drive_point();
			status = '0;
			status[STATUS_AR_LSB +: AR_SEL_W] = ar_sel_t'(ar);
			sample_point();
			check_aspect("video_arx", video_arx, ref_arx(ar_sel_t'(ar)));
			check_aspect("video_ary", video_ary, ref_ary(ar_sel_t'(ar)));
		end

		// Mount reports, one slot pulse at a time
		exp_hdd    = '0;
		exp_floppy = '0;
		repeat (48) begin
			drive_point();
			ev.mounted  = slot_mask_t'(1) << rand_bits(2);
			ev.size     = rand_bit() ? '0 : img_size_t'(rand_bits(IMG_W));
			ev.readonly = rand_bit();
			image_event = ev;
			exp_hdd     = ref_hdd_after(exp_hdd, ev);
			exp_floppy  = ref_floppy_after(exp_floppy, ev);
			drive_point();
			image_event = '0;
			sample_point();
			check_hdd_status(hdd_status, exp_hdd);
			check_floppy_status(floppy_status, exp_floppy);
		end

		// Single reads and writes
		repeat (16) begin
			req_a = random_request();
			issue_request(req_a);
			drive_point();
			hdd_req_valid = 1'b0;
			track_request(req_a);
		end

		// Second request held valid while the first is served
		repeat (8) begin
			req_a = random_request();
			req_b = random_request();
			issue_request(req_a);
			drive_point();
			hdd_req = req_b;
			track_request(req_a);
			drive_point();
			hdd_req_valid = 1'b0;
			track_request(req_b);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== blockdev_bridge.f ====
+incdir+testbench
rtl/bridge_cfg_pkg.sv
rtl/blockdev_types_pkg.sv
rtl/core_control.sv
rtl/image_mount_tracker.sv
rtl/hdd_request_ctrl.sv
rtl/blockdev_bridge.sv
testbench/tb_blockdev_bridge.sv

// ==== Bender.yml ====
package:
  name: blockdev_bridge

sources:
  - rtl/bridge_cfg_pkg.sv
  - rtl/blockdev_types_pkg.sv
  - rtl/core_control.sv
  - rtl/image_mount_tracker.sv
  - rtl/hdd_request_ctrl.sv
  - rtl/blockdev_bridge.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_blockdev_bridge.sv
